/* Makefile */
SIM = obj_dir/Vrs_tb

all: run

$(SIM): sim.f $(wildcard hdl/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -sv -f sim.f --top-module rs_tb -o Vrs_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* bench/rs_tb.sv */
module rs_tb
  import rs_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  // cycle budget of reset and the five tests
  localparam int RUN_CYCLES = 3 + 8 * 6 + 30 + 20 + 40 + 40;
  localparam int WATCHDOG_NS = (RUN_CYCLES + 100) * CLK_PERIOD;

  logic in_clk;
  logic in_rst_n;
  logic dispatch_valid;
  dispatch_t dispatch;
  bcast_t bcast;
  logic alu_ready;
  logic flush;
  logic full;
  logic result_valid;
  result_t result;

  logic [31:0] lfsr_q;
  int errors;
  int checks;
  int tests;

  rs_alu_top uut (.*);

  initial begin
    in_clk = 1'b0;
    forever #(CLK_PERIOD / 2) in_clk = ~in_clk;
  end

  // fibonacci lfsr on taps 32 22 2 1
  // stepped once per bit taken
  function automatic logic [31:0] rand_word(input int nbits);
    logic [31:0] w;
    logic fb;
    w = '0;
    for (int k = 0; k < nbits; k++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  // reference alu returning {nzcv, value}
  function automatic logic [DATA_W+3:0] alu_model(alu_op_t op, logic [DATA_W-1:0] a,
                                                  logic [DATA_W-1:0] b, logic cin);
    logic [DATA_W:0] wide;
    logic [DATA_W-1:0] r;
    logic c;
    logic v;
    r = '0;
    c = 1'b0;
    v = 1'b0;
    case (op)
      ADD, ADC: begin
        wide = {1'b0, a} + {1'b0, b} + (DATA_W + 1)'(op == ADC && cin);
        r = wide[DATA_W-1:0];
        c = wide[DATA_W];
        v = (a[DATA_W-1] == b[DATA_W-1]) && (r[DATA_W-1] != a[DATA_W-1]);
      end
      SUB: begin
        r = a - b;
        // carry set when no borrow
        c = (a >= b);
        v = (a[DATA_W-1] != b[DATA_W-1]) && (r[DATA_W-1] != a[DATA_W-1]);
      end
      AND: r = a & b;
      ORR: r = a | b;
      EOR: r = a ^ b;
      LSL: r = a << b[4:0];
      LSR: r = a >> b[4:0];
      default: r = '0;
    endcase
    return {r[DATA_W-1], r == '0, c, v, r};
  endfunction

  // operands and flags ready with the given carry
  function automatic dispatch_t make_disp(alu_op_t op, logic [DATA_W-1:0] a,
                                          logic [DATA_W-1:0] b, logic cin,
                                          logic [TAG_W-1:0] dst);
    dispatch_t d;
    d = '0;
    d.op = op;
    d.set_nzcv = 1'b1;
    d.uses_nzcv = (op == ADC);
    d.a.ready = 1'b1;
    d.a.value = a;
    d.b.ready = 1'b1;
    d.b.value = b;
    d.flags.ready = 1'b1;
    d.flags.nzcv.c = cin;
    d.dst_tag = dst;
    return d;
  endfunction

  function automatic bcast_t make_bcast(logic [TAG_W-1:0] tag, logic [DATA_W-1:0] value,
                                        logic set_nzcv, logic [3:0] nzcv);
    bcast_t bc;
    bc.valid = 1'b1;
    bc.tag = tag;
    bc.value = value;
    bc.set_nzcv = set_nzcv;
    bc.nzcv = nzcv;
    return bc;
  endfunction

  task automatic check(input string name, input logic [DATA_W-1:0] got,
                       input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // one cycle of stimulus applied at the rising edge
  task automatic drive(input logic dv, input dispatch_t d, input bcast_t bc);
    @(posedge in_clk);
    dispatch_valid <= dv;
    dispatch <= d;
    bcast <= bc;
  endtask

  // count edges until result_valid
  // sampled at the falling edge
  task automatic wait_result(input int limit, output int edges);
    edges = 0;
    do begin
      @(posedge in_clk);
      edges++;
      @(negedge in_clk);
    end while (!result_valid && edges < limit);
    if (!result_valid) begin
      errors++;
      $display("no result within %0d cycles at %0t ns", limit, $time);
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge in_clk);
      check("result_valid", DATA_W'(result_valid), '0);
    end
  endtask

  task automatic verify_result(input logic [TAG_W-1:0] tag, input logic set_nzcv,
                               input logic [DATA_W+3:0] exp);
    check("result.dst_tag", DATA_W'(result.dst_tag), DATA_W'(tag));
    check("result.value", result.value, exp[DATA_W-1:0]);
    check("result.set_nzcv", DATA_W'(result.set_nzcv), DATA_W'(set_nzcv));
    // flags only carry meaning when the op sets them
    if (set_nzcv) begin
      check("result.nzcv", DATA_W'(result.nzcv), DATA_W'(exp[DATA_W+3:DATA_W]));
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("[%0t ns] %s finished, %0d errors", $time, name, errors - err_before);
  endtask

  task automatic reset_state();
    int e0;
    e0 = errors;
    @(negedge in_clk);
    check("full", DATA_W'(full), '0);
    check("result_valid", DATA_W'(result_valid), '0);
    end_test("reset", e0);
  endtask

  // one op of each kind with latency fixed at two edges
  task automatic basic_ops();
    int e0;
    int edges;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [31:0] w;
    alu_op_t op;
    dispatch_t d;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      op = alu_op_t'(i[2:0]);
      a = rand_word(DATA_W);
      b = rand_word(DATA_W);
      // carry in from bit 0
      // set_nzcv request from bit 1
      w = rand_word(2);
      d = make_disp(op, a, b, w[0], TAG_W'(i + 1));
      d.set_nzcv = w[1];
      drive(1'b1, d, '0);
      drive(1'b0, '0, '0);
      wait_result(4, edges);
      check("latency", DATA_W'(edges), 2);
      verify_result(TAG_W'(i + 1), w[1], alu_model(op, a, b, w[0]));
    end
    end_test("basic_ops", e0);
  endtask

  task automatic wakeup();
    int e0;
    int edges;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    dispatch_t d;
    e0 = errors;
    a = rand_word(DATA_W);
    b = rand_word(DATA_W);
    // operand a waits on tag 3
    d = make_disp(ADD, '0, b, 1'b0, 4'hA);
    d.a.ready = 1'b0;
    d.a.tag = 4'd3;
    drive(1'b1, d, '0);
    drive(1'b0, '0, '0);
    expect_quiet(4);
    drive(1'b0, '0, make_bcast(4'd3, a, 1'b0, 4'b0000));
    drive(1'b0, '0, '0);
    wait_result(4, edges);
    verify_result(4'hA, 1'b1, alu_model(ADD, a, b, 1'b0));
    // broadcast in the dispatch cycle goes through the bypass
    b = rand_word(DATA_W);
    d = make_disp(SUB, a, '0, 1'b0, 4'hB);
    d.b.ready = 1'b0;
    d.b.tag = 4'd6;
    drive(1'b1, d, make_bcast(4'd6, b, 1'b0, 4'b0000));
    drive(1'b0, '0, '0);
    wait_result(4, edges);
    check("latency", DATA_W'(edges), 2);
    verify_result(4'hB, 1'b1, alu_model(SUB, a, b, 1'b0));
    end_test("wakeup", e0);
  endtask

  task automatic flag_wakeup();
    int e0;
    int edges;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    dispatch_t d;
    e0 = errors;
    a = rand_word(DATA_W);
    b = rand_word(DATA_W);
    d = make_disp(ADC, a, b, 1'b0, 4'hC);
    d.flags.ready = 1'b0;
    d.flags.tag = 4'd9;
    drive(1'b1, d, '0);
    drive(1'b0, '0, '0);
    // producer without set_nzcv leaves the flags pending
    drive(1'b0, '0, make_bcast(4'd9, '0, 1'b0, 4'b0010));
    drive(1'b0, '0, '0);
    expect_quiet(3);
    drive(1'b0, '0, make_bcast(4'd9, '0, 1'b1, 4'b0010));
    drive(1'b0, '0, '0);
    wait_result(4, edges);
    verify_result(4'hC, 1'b1, alu_model(ADC, a, b, 1'b1));
    end_test("flags", e0);
  endtask

  task automatic backpressure();
    int e0;
    int edges;
    logic [DATA_W+3:0] exp_tab [RS_DEPTH];
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [31:0] w;
    alu_op_t op;
    e0 = errors;
    @(posedge in_clk);
    alu_ready <= 1'b0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      w = rand_word(3);
      op = alu_op_t'(w[2:0]);
      a = rand_word(DATA_W);
      b = rand_word(DATA_W);
      exp_tab[i] = alu_model(op, a, b, 1'b0);
      drive(1'b1, make_disp(op, a, b, 1'b0, TAG_W'(i)), '0);
    end
    drive(1'b0, '0, '0);
    @(negedge in_clk);
    check("full", DATA_W'(full), 1);
    check("result_valid", DATA_W'(result_valid), '0);
    @(posedge in_clk);
    alu_ready <= 1'b1;
    for (int i = 0; i < RS_DEPTH; i++) begin
      wait_result(6, edges);
      // lowest index issues first so tags return in dispatch order
      verify_result(TAG_W'(i), 1'b1, exp_tab[i]);
    end
    @(negedge in_clk);
    check("full", DATA_W'(full), '0);
    end_test("backpressure", e0);
  endtask

  task automatic flush_recovery();
    int e0;
    int edges;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    dispatch_t d;
    e0 = errors;
    @(posedge in_clk);
    alu_ready <= 1'b0;
    // seven entries wait on tag 12
    // the last one is ready
    for (int i = 0; i < RS_DEPTH; i++) begin
      d = make_disp(ORR, rand_word(DATA_W), rand_word(DATA_W), 1'b0, TAG_W'(i));
      if (i < RS_DEPTH - 1) begin
        d.a.ready = 1'b0;
        d.a.tag = 4'd12;
      end
      drive(1'b1, d, '0);
    end
    drive(1'b0, '0, '0);
    @(negedge in_clk);
    check("full", DATA_W'(full), 1);
    @(posedge in_clk);
    alu_ready <= 1'b1;
    // flush lands while the ready entry sits in the alu
    @(posedge in_clk);
    flush <= 1'b1;
    @(posedge in_clk);
    flush <= 1'b0;
    expect_quiet(2);
    check("full", DATA_W'(full), '0);
    drive(1'b0, '0, make_bcast(4'd12, 32'h1234_5678, 1'b0, 4'b0000));
    drive(1'b0, '0, '0);
    expect_quiet(4);
    a = rand_word(DATA_W);
    b = rand_word(DATA_W);
    drive(1'b1, make_disp(ADD, a, b, 1'b0, 4'hD), '0);
    drive(1'b0, '0, '0);
    wait_result(4, edges);
    verify_result(4'hD, 1'b1, alu_model(ADD, a, b, 1'b0));
    end_test("flush", e0);
  endtask

  // backstop if a wait loop ever stalls
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    lfsr_q = 32'h8704;
    errors = 0;
    checks = 0;
    tests = 0;
    in_rst_n = 1'b0;
    dispatch_valid = 1'b0;
    dispatch = '0;
    bcast = '0;
    alu_ready = 1'b1;
    flush = 1'b0;
    repeat (3) @(posedge in_clk);
    in_rst_n <= 1'b1;
    reset_state();
    basic_ops();
    wakeup();
    flag_wakeup();
    backpressure();
    flush_recovery();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* hdl/alu_unit.sv */
module alu_unit
  import rs_pkg::*;
(
  input  logic    in_clk,
  input  logic    in_rst_n,
  input  logic    issue_valid,
  input  issue_t  issue,
  input  logic    kill,
  output logic    result_valid,
  output result_t result
);

  logic [DATA_W-1:0] addend;
  logic [DATA_W-1:0] value;
  logic [DATA_W:0] sum;
  logic [SHAMT_W-1:0] shamt;
  logic carry_in;
  logic carry;
  logic overflow;

  assign shamt = issue.b[SHAMT_W-1:0];

  // one adder for add, adc and sub
  // sub is a plus not b plus one so carry means no borrow
  assign addend = (issue.op == SUB) ? ~issue.b : issue.b;
  assign carry_in = (issue.op == SUB) || ((issue.op == ADC) && issue.nzcv.c);
  assign sum = {1'b0, issue.a} + {1'b0, addend} + {{DATA_W{1'b0}}, carry_in};

  always_comb begin
    value = '0;
    carry = 1'b0;
    overflow = 1'b0;
    unique case (issue.op)
      ADD, ADC, SUB: begin
        value = sum[DATA_W-1:0];
        carry = sum[DATA_W];
        // signs of inputs agree but result sign differs
        overflow = (issue.a[DATA_W-1] == addend[DATA_W-1])
                   && (sum[DATA_W-1] != issue.a[DATA_W-1]);
      end
      AND: value = issue.a & issue.b;
      ORR: value = issue.a | issue.b;
      EOR: value = issue.a ^ issue.b;
      LSL: value = issue.a << shamt;
      LSR: value = issue.a >> shamt;
    endcase
  end

  // valid pulse dropped when a flush hits the in-flight op
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue_valid && !kill;
    end
  end

  // result payload, nzcv only meaningful with set_nzcv
  always_ff @(posedge in_clk) begin
    if (issue_valid) begin
      result.dst_tag <= issue.dst_tag;
      result.value <= value;
      result.set_nzcv <= issue.set_nzcv;
      result.nzcv <= '{n: value[DATA_W-1], z: (value == '0), c: carry, v: overflow};
    end
  end

endmodule

/* hdl/rs_alu_top.sv */
module rs_alu_top
  import rs_pkg::*;
(
  input  logic      in_clk,
  input  logic      in_rst_n,
  input  logic      dispatch_valid,
  input  dispatch_t dispatch,
  input  bcast_t    bcast,
  input  logic      alu_ready,
  input  logic      flush,
  output logic      full,
  output logic      result_valid,
  output result_t   result
);

  // station state seen by the selector
  logic [RS_DEPTH-1:0] occupied;
  logic [RS_DEPTH-1:0] ready;
  // picks with the extra "none" bit
  logic [RS_PICK_W-1:0] free_idx;
  logic [RS_PICK_W-1:0] ready_idx;
  // control commands
  logic write_en;
  logic issue_en;
  logic clear_all;
  logic issue_valid;
  logic kill;
  issue_t issue;

  rs_station u_station (
    .in_clk    (in_clk),
    .in_rst_n  (in_rst_n),
    .write_en  (write_en),
    .write_idx (free_idx[RS_IDX_W-1:0]),
    .dispatch  (dispatch),
    .bcast     (bcast),
    .issue_en  (issue_en),
    .issue_idx (ready_idx[RS_IDX_W-1:0]),
    .clear_all (clear_all),
    .occupied  (occupied),
    .ready     (ready),
    .issue     (issue)
  );

  rs_select u_select (
    .in_clk    (in_clk),
    .in_rst_n  (in_rst_n),
    .occupied  (occupied),
    .ready     (ready),
    .free_idx  (free_idx),
    .ready_idx (ready_idx)
  );

  rs_ctrl u_ctrl (
    .in_clk         (in_clk),
    .in_rst_n       (in_rst_n),
    .dispatch_valid (dispatch_valid),
    .alu_ready      (alu_ready),
    .flush          (flush),
    .free_idx       (free_idx),
    .ready_idx      (ready_idx),
    .write_en       (write_en),
    .issue_en       (issue_en),
    .issue_valid    (issue_valid),
    .clear_all      (clear_all),
    .kill           (kill),
    .full           (full)
  );

  alu_unit u_alu (
    .in_clk       (in_clk),
    .in_rst_n     (in_rst_n),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .kill         (kill),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

/* hdl/rs_ctrl.sv */
module rs_ctrl
  import rs_pkg::*;
(
  input  logic                 in_clk,
  input  logic                 in_rst_n,
  input  logic                 dispatch_valid,
  input  logic                 alu_ready,
  input  logic                 flush,
  input  logic [RS_PICK_W-1:0] free_idx,
  input  logic [RS_PICK_W-1:0] ready_idx,
  output logic                 write_en,
  output logic                 issue_en,
  output logic                 issue_valid,
  output logic                 clear_all,
  output logic                 kill,
  output logic                 full
);

  // no free slot left
  assign full = (free_idx == RS_NONE);

  // dispatch dropped during flush
  assign write_en = dispatch_valid && !full && !flush;

  // issue needs a ready slot and an idle alu
  assign issue_en = alu_ready && !flush && (ready_idx != RS_NONE);

  // mispredict empties every slot at the next edge
  assign clear_all = flush;

  // valid travels with the registered issue payload
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= issue_en;
    end
  end

  // an issue already in the alu gets cancelled
  assign kill = flush && issue_valid;

  // rename side must stall on full
  a_no_dispatch_when_full : assert property (
    @(posedge in_clk) disable iff (!in_rst_n)
    dispatch_valid |-> !full
  ) else $error("dispatch while station full");

endmodule

/* hdl/rs_pkg.sv */
package rs_pkg;

  // datapath and tag sizes
  localparam int unsigned DATA_W = 32;
  localparam int unsigned TAG_W = 4;

  // station geometry
  localparam int unsigned RS_DEPTH = 8;
  localparam int unsigned RS_IDX_W = 3;
  // picks carry one extra bit so RS_DEPTH can mean "none"
  localparam int unsigned RS_PICK_W = RS_IDX_W + 1;
  localparam logic [RS_PICK_W-1:0] RS_NONE = RS_PICK_W'(RS_DEPTH);

  // shift amount taken from the low bits of b
  localparam int unsigned SHAMT_W = 5;

  typedef enum logic [2:0] {
    ADD,
    ADC,
    SUB,
    AND,
    ORR,
    EOR,
    LSL,
    LSR
  } alu_op_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // one source operand, either a value or a pending rob tag
  typedef struct packed {
    logic ready;
    logic [TAG_W-1:0] tag;
    logic [DATA_W-1:0] value;
  } operand_t;

  // flags source, same scheme as an operand
  typedef struct packed {
    logic ready;
    logic [TAG_W-1:0] tag;
    nzcv_t nzcv;
  } flag_src_t;

  typedef struct packed {
    alu_op_t op;
    logic set_nzcv;
    logic uses_nzcv;
    operand_t a;
    operand_t b;
    flag_src_t flags;
    logic [TAG_W-1:0] dst_tag;
  } dispatch_t;

  typedef struct packed {
    logic occupied;
    dispatch_t instr;
  } rs_entry_t;

  // result broadcast from the rob
  typedef struct packed {
    logic valid;
    logic [TAG_W-1:0] tag;
    logic [DATA_W-1:0] value;
    logic set_nzcv;
    nzcv_t nzcv;
  } bcast_t;

  typedef struct packed {
    alu_op_t op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    nzcv_t nzcv;
    logic set_nzcv;
    logic [TAG_W-1:0] dst_tag;
  } issue_t;

  typedef struct packed {
    logic [TAG_W-1:0] dst_tag;
    logic [DATA_W-1:0] value;
    logic set_nzcv;
    nzcv_t nzcv;
  } result_t;

endpackage

/* hdl/rs_select.sv */
module rs_select
  import rs_pkg::*;
(
  input  logic                 in_clk,
  input  logic                 in_rst_n,
  input  logic [RS_DEPTH-1:0]  occupied,
  input  logic [RS_DEPTH-1:0]  ready,
  output logic [RS_PICK_W-1:0] free_idx,
  output logic [RS_PICK_W-1:0] ready_idx
);

  // lowest set bit of a request vector
  // returns RS_NONE when no bit is set
  function automatic logic [RS_PICK_W-1:0] lowest_set(logic [RS_DEPTH-1:0] req);
    logic [RS_PICK_W-1:0] pick;
    pick = RS_NONE;
    // walk down so the lowest index wins
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (req[i]) begin
        pick = RS_PICK_W'(i);
      end
    end
    return pick;
  endfunction

  // free slot for the next dispatch
  assign free_idx = lowest_set(~occupied);

  // oldest-by-index ready slot for the alu
  assign ready_idx = lowest_set(ready);

  // a ready entry must also hold an instruction
  // otherwise issue would fire on a stale slot
  a_ready_implies_occupied : assert property (
    @(posedge in_clk) disable iff (!in_rst_n)
    (ready & ~occupied) == '0
  ) else $error("ready set on an unoccupied entry: ready=%b occ=%b", ready, occupied);

endmodule

/* hdl/rs_station.sv */
module rs_station
  import rs_pkg::*;
(
  input  logic                in_clk,
  input  logic                in_rst_n,
  input  logic                write_en,
  input  logic [RS_IDX_W-1:0] write_idx,
  input  dispatch_t           dispatch,
  input  bcast_t              bcast,
  input  logic                issue_en,
  input  logic [RS_IDX_W-1:0] issue_idx,
  input  logic                clear_all,
  output logic [RS_DEPTH-1:0] occupied,
  output logic [RS_DEPTH-1:0] ready,
  output issue_t              issue
);

  // occupancy is control state, slot contents are payload
  logic [RS_DEPTH-1:0] occ_q;
  dispatch_t slot_q [RS_DEPTH];
  rs_entry_t entry [RS_DEPTH];
  dispatch_t pick;

  // operand capture on a matching tag
  function automatic operand_t wake_operand(operand_t op, bcast_t bc);
    operand_t res;
    res = op;
    if (bc.valid && !op.ready && op.tag == bc.tag) begin
      res.ready = 1'b1;
      res.value = bc.value;
    end
    return res;
  endfunction

  // flags only wake from a producer that set them
  function automatic flag_src_t wake_flags(flag_src_t fl, bcast_t bc);
    flag_src_t res;
    res = fl;
    if (bc.valid && bc.set_nzcv && !fl.ready && fl.tag == bc.tag) begin
      res.ready = 1'b1;
      res.nzcv = bc.nzcv;
    end
    return res;
  endfunction

  // same compare serves stored entries and the incoming dispatch
  function automatic dispatch_t wake(dispatch_t d, bcast_t bc);
    dispatch_t res;
    res = d;
    res.a = wake_operand(d.a, bc);
    res.b = wake_operand(d.b, bc);
    res.flags = wake_flags(d.flags, bc);
    return res;
  endfunction

  // occupied bits set on write, cleared on issue or flush
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      occ_q <= '0;
    end else if (clear_all) begin
      occ_q <= '0;
    end else begin
      // write and issue never target the same slot
      if (issue_en) begin
        occ_q[issue_idx] <= 1'b0;
      end
      if (write_en) begin
        occ_q[write_idx] <= 1'b1;
      end
    end
  end

  // slot payload with wakeup every cycle
  always_ff @(posedge in_clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (write_en && write_idx == RS_IDX_W'(i)) begin
        // bypass for a broadcast landing with the dispatch
        slot_q[i] <= wake(dispatch, bcast);
      end else if (occ_q[i]) begin
        slot_q[i] <= wake(slot_q[i], bcast);
      end
    end
  end

  // entry view and ready vector
  for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
    assign entry[i].occupied = occ_q[i];
    assign entry[i].instr = slot_q[i];
    assign ready[i] = entry[i].occupied && entry[i].instr.a.ready && entry[i].instr.b.ready
                      && (!entry[i].instr.uses_nzcv || entry[i].instr.flags.ready);
  end

  assign occupied = occ_q;
  assign pick = slot_q[issue_idx];

  // issue register feeds the alu one cycle after the pick
  always_ff @(posedge in_clk) begin
    if (issue_en) begin
      issue.op <= pick.op;
      issue.a <= pick.a.value;
      issue.b <= pick.b.value;
      issue.nzcv <= pick.flags.nzcv;
      issue.set_nzcv <= pick.set_nzcv;
      issue.dst_tag <= pick.dst_tag;
    end
  end

  // the selector must only hand out free slots
  a_no_overwrite : assert property (
    @(posedge in_clk) disable iff (!in_rst_n)
    write_en |-> !occ_q[write_idx]
  ) else $error("dispatch written over occupied entry %0d", write_idx);

endmodule

/* sim.f */
hdl/rs_pkg.sv
hdl/rs_select.sv
hdl/rs_station.sv
hdl/rs_ctrl.sv
hdl/alu_unit.sv
hdl/rs_alu_top.sv
bench/rs_tb.sv
